// ==== sources.f ====
+incdir+.
icache_pkg.sv
mem_bus_pkg.sv
icache_way.sv
icache_hit_select.sv
icache_ctrl.sv
icache_top.sv
icache_assert.sv
tb_icache.sv

// ==== Bender.yml ====
package:
  name: icache

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - icache_pkg.sv
      - mem_bus_pkg.sv
      - icache_way.sv
      - icache_hit_select.sv
      - icache_ctrl.sv
      - icache_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - icache_assert.sv
      - tb_icache.sv

// ==== tb_icache.sv ====
`timescale 1ns/1ps
`include "icache_defs.svh"

module tb_icache
    import icache_pkg::*, mem_bus_pkg::*;
();

    localparam logic [31:0] word_key = 32'h5a5a_0000;
    // about 220 requests at up to about 40 cycles per miss, with wide margin
    localparam int max_cycles = 20000;

    logic        clk;
    logic        rst;
    logic        req_valid;
    logic        req_ready;
    fetch_addr_t req_addr;
    logic        resp_valid;
    word_t       resp_data;
    logic        ar_valid;
    logic        ar_ready;
    fetch_addr_t ar_addr;
    logic        r_valid;
    r_beat_t     r_beat;

    int          cycles = 0;
    int          errors;
    int          checks;
    int          tests_failed;
    int          addr_count;
    int          predicted_misses;
    logic [31:0] last_ar_addr;

    // reference cache state
    tag_t        ref_tag   [`ICACHE_SETS][`ICACHE_WAYS];
    logic        ref_valid [`ICACHE_SETS][`ICACHE_WAYS];
    logic        ref_root  [`ICACHE_SETS];
    logic        ref_p0    [`ICACHE_SETS];
    logic        ref_p1    [`ICACHE_SETS];

    icache_top DUT (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req_addr   (req_addr),
        .resp_valid (resp_valid),
        .resp_data  (resp_data),
        .ar_valid   (ar_valid),
        .ar_ready   (ar_ready),
        .ar_addr    (ar_addr),
        .r_valid    (r_valid),
        .r_beat     (r_beat)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= max_cycles) begin
            $display("timeout: the run did not finish within %0d cycles", max_cycles);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic word_t mem_word(input logic [31:0] addr);
        return {addr[31:2], 2'b00} ^ word_key;
    endfunction

    // memory model with random ar_ready delay and gaps between beats
    initial begin : mem_model
        logic [31:0] seed;
        logic [31:0] line;
        seed = 32'ha3c;
        ar_ready = 1'b0;
        r_valid = 1'b0;
        r_beat = '0;
        addr_count = 0;
        last_ar_addr = '0;
        forever begin
            @(negedge clk);
            if (ar_valid && !rst) begin
                seed = lcg_next(seed);
                repeat (seed[17:16]) @(negedge clk);
                line = ar_addr;
                ar_ready = 1'b1;
                @(negedge clk);
                ar_ready = 1'b0;
                addr_count++;
                last_ar_addr = line;
                for (int b = 0; b < `ICACHE_LINE_WORDS; b++) begin
                    seed = lcg_next(seed);
                    if (seed[16]) begin
                        @(negedge clk);
                    end
                    r_valid = 1'b1;
                    r_beat.data = mem_word(line + 32'(b * 4));
                    r_beat.last = (b == `ICACHE_LINE_WORDS - 1);
                    @(negedge clk);
                    r_valid = 1'b0;
                    r_beat.last = 1'b0;
                end
            end
        end
    end

    // returns 1 on a predicted miss; a miss fills the victim and the replay hits it
    function automatic logic ref_access(input logic [31:0] addr);
        fetch_addr_t a;
        int          way;
        logic        miss;
        a = addr;
        way = -1;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (ref_valid[a.index][w] && ref_tag[a.index][w] == a.tag) begin
                way = w;
            end
        end
        miss = (way < 0);
        if (miss) begin
            if (ref_root[a.index]) begin
                way = 2 + int'(ref_p1[a.index]);
            end else begin
                way = int'(ref_p0[a.index]);
            end
            ref_valid[a.index][way] = 1'b1;
            ref_tag[a.index][way] = a.tag;
        end
        // root points at the other pair and the pair bit at the sibling
        ref_root[a.index] = (way < 2);
        if (way < 2) begin
            ref_p0[a.index] = (way == 0);
        end else begin
            ref_p1[a.index] = (way == 2);
        end
        return miss;
    endfunction

    task automatic check_value(input string test, input string what,
                               input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (act === exp)
        else begin
            $display("error in %s: %s expected %h actual %h", test, what, exp, act);
            errors++;
        end
    endtask

    task automatic report_test(input string test, input int errors_before);
        if (errors == errors_before) begin
            $display("%s: ok", test);
        end else begin
            $display("%s: %0d errors", test, errors - errors_before);
            tests_failed++;
        end
    endtask

    // starts at a falling edge and returns at the one that shows the response
    task automatic fetch_one(input logic [31:0] addr, output word_t data, output int lat);
        req_addr = addr;
        req_valid = 1'b1;
        while (!req_ready) begin
            @(negedge clk);
        end
        @(negedge clk);
        req_valid = 1'b0;
        lat = 1;
        while (!resp_valid) begin
            @(negedge clk);
            lat++;
        end
        data = resp_data;
    endtask

    task automatic fetch_and_check(input string test, input logic [31:0] addr, output int lat);
        int    count_before;
        logic  miss;
        word_t data;
        count_before = addr_count;
        miss = ref_access(addr);
        predicted_misses += int'(miss);
        fetch_one(addr, data, lat);
        check_value(test, "word", mem_word(addr), data);
        check_value(test, "addresses issued", 32'(miss), 32'(addr_count - count_before));
    endtask

    task automatic after_reset();
        int e;
        e = errors;
        check_value("reset", "req_ready", 32'd1, 32'(req_ready));
        check_value("reset", "ar_valid", 32'd0, 32'(ar_valid));
        check_value("reset", "resp_valid", 32'd0, 32'(resp_valid));
        report_test("reset", e);
    endtask

    task automatic cold_miss();
        int e;
        int lat;
        e = errors;
        fetch_and_check("cold_miss", 32'h0000_2044, lat);
        check_value("cold_miss", "line address", 32'h0000_2040, last_ar_addr);
        report_test("cold_miss", e);
    endtask

    task automatic hit_after_fill();
        int e;
        int lat;
        e = errors;
        fetch_and_check("hit_after_fill", 32'h0000_2058, lat);
        check_value("hit_after_fill", "latency", 32'd1, 32'(lat));
        report_test("hit_after_fill", e);
    endtask

    task automatic back_to_back_hits();
        int          e;
        int          count_before;
        logic [31:0] base;
        e = errors;
        base = 32'h0000_2040;
        count_before = addr_count;
        for (int i = 0; i < `ICACHE_LINE_WORDS; i++) begin
            void'(ref_access(base + 32'(((3 * i) % 8) * 4)));
        end
        req_addr = base;
        req_valid = 1'b1;
        while (!req_ready) begin
            @(negedge clk);
        end
        for (int i = 1; i <= `ICACHE_LINE_WORDS; i++) begin
            @(negedge clk);
            check_value("back_to_back", "resp_valid", 32'd1, 32'(resp_valid));
            check_value("back_to_back", "word",
                        mem_word(base + 32'(((3 * (i - 1)) % 8) * 4)), resp_data);
            if (i < `ICACHE_LINE_WORDS) begin
                req_addr = base + 32'(((3 * i) % 8) * 4);
            end else begin
                req_valid = 1'b0;
            end
        end
        check_value("back_to_back", "addresses issued", 32'd0, 32'(addr_count - count_before));
        report_test("back_to_back", e);
    endtask

    // five tags in set 20 force evictions
    task automatic replacement_order();
        int e;
        int lat;
        int seq [11] = '{0, 1, 2, 3, 0, 4, 1, 0, 2, 4, 3};
        e = errors;
        foreach (seq[i]) begin
            fetch_and_check("replacement", (32'(seq[i] + 'h100) << 12) | (32'd20 << 5), lat);
        end
        report_test("replacement", e);
    endtask

    task automatic random_fetches();
        int          e;
        int          lat;
        int          count_before;
        int          miss_before;
        logic [31:0] seed;
        logic [31:0] r;
        e = errors;
        seed = 32'ha3c;
        count_before = addr_count;
        miss_before = predicted_misses;
        for (int i = 0; i < 200; i++) begin
            seed = lcg_next(seed);
            r = seed >> 16;
            fetch_and_check("random", 32'h0004_0000 | (32'(r[2:0]) << 12)
                            | (32'(r[4:3]) << 5) | (32'(r[7:5]) << 2), lat);
        end
        check_value("random", "total misses", 32'(predicted_misses - miss_before),
                    32'(addr_count - count_before));
        report_test("random", e);
    endtask

    initial begin
        errors = 0;
        checks = 0;
        tests_failed = 0;
        predicted_misses = 0;
        for (int s = 0; s < `ICACHE_SETS; s++) begin
            ref_root[s] = 1'b0;
            ref_p0[s] = 1'b0;
            ref_p1[s] = 1'b0;
            for (int w = 0; w < `ICACHE_WAYS; w++) begin
                ref_valid[s][w] = 1'b0;
                ref_tag[s][w] = '0;
            end
        end
        rst = 1'b1;
        req_valid = 1'b0;
        req_addr = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        after_reset();
        cold_miss();
        hit_after_fill();
        back_to_back_hits();
        replacement_order();
        random_fetches();
        assert (DUT.u_assert.fail_count == 0)
        else begin
            $display("bus protocol assertions failed %0d times", DUT.u_assert.fail_count);
            errors++;
        end
        $display("tests failed %0d, checks %0d, errors %0d", tests_failed, checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== icache_assert.sv ====
`timescale 1ns/1ps

module icache_assert
    import icache_pkg::*, mem_bus_pkg::*;
(
    input logic        clk,
    input logic        rst,
    input logic        ar_valid,
    input logic        ar_ready,
    input fetch_addr_t ar_addr,
    input logic        r_valid,
    input r_beat_t     r_beat,
    input logic        resp_valid
);

    int unsigned fail_count = 0;
    logic        burst_open;

    // open from the address handshake until the last beat
    always_ff @(posedge clk) begin
        if (rst) begin
            burst_open <= 1'b0;
        end else if (ar_valid && ar_ready) begin
            burst_open <= 1'b1;
        end else if (r_valid && r_beat.last) begin
            burst_open <= 1'b0;
        end
    end

    ar_hold: assert property (@(posedge clk) disable iff (rst)
        ar_valid && !ar_ready |=> ar_valid && $stable(ar_addr))
    else begin
        $error("ar_valid dropped or ar_addr changed before ar_ready");
        fail_count++;
    end

    ar_aligned: assert property (@(posedge clk) disable iff (rst)
        ar_valid |-> ar_addr.offset == '0 && ar_addr.byte_sel == '0)
    else begin
        $error("ar_addr is not line aligned");
        fail_count++;
    end

    ar_one_burst: assert property (@(posedge clk) disable iff (rst)
        burst_open |-> !ar_valid)
    else begin
        $error("new address issued before the last beat");
        fail_count++;
    end

    resp_not_in_refill: assert property (@(posedge clk) disable iff (rst)
        resp_valid |-> !ar_valid)
    else begin
        $error("resp_valid high while ar_valid is high");
        fail_count++;
    end

endmodule

bind icache_top icache_assert u_assert (
    .clk        (clk),
    .rst        (rst),
    .ar_valid   (ar_valid),
    .ar_ready   (ar_ready),
    .ar_addr    (ar_addr),
    .r_valid    (r_valid),
    .r_beat     (r_beat),
    .resp_valid (resp_valid)
);

// ==== icache_top.sv ====
`timescale 1ns/1ps
`include "icache_defs.svh"

module icache_top
    import icache_pkg::*, mem_bus_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    // cpu fetch side
    input  logic        req_valid,
    output logic        req_ready,
    input  fetch_addr_t req_addr,
    output logic        resp_valid,
    output word_t       resp_data,

    // memory read side
    output logic        ar_valid,
    input  logic        ar_ready,
    output fetch_addr_t ar_addr,
    input  logic        r_valid,
    input  r_beat_t     r_beat
);

    lookup_t   lookup;
    fill_t     fill;
    way_mask_t victim;
    tag_t      req_tag;
    logic      hit;
    way_idx_t  hit_way;
    way_out_t  way_res [`ICACHE_WAYS];

    icache_ctrl u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req_addr   (req_addr),
        .req_ready  (req_ready),
        .resp_valid (resp_valid),
        .req_tag    (req_tag),
        .hit        (hit),
        .hit_way    (hit_way),
        .lookup     (lookup),
        .fill       (fill),
        .victim     (victim),
        .ar_valid   (ar_valid),
        .ar_ready   (ar_ready),
        .ar_addr    (ar_addr),
        .r_valid    (r_valid),
        .r_beat     (r_beat)
    );

    for (genvar i = 0; i < `ICACHE_WAYS; i++) begin : g_way
        icache_way u_way (
            .clk      (clk),
            .rst      (rst),
            .lookup   (lookup),
            .cmp_tag  (req_tag),
            .fill     (fill),
            .fill_sel (victim[i]),
            .result   (way_res[i])
        );
    end

    icache_hit_select u_hit_select (
        .results (way_res),
        .hit     (hit),
        .hit_way (hit_way),
        .word    (resp_data)
    );

endmodule

// ==== icache_ctrl.sv ====
`timescale 1ns/1ps
`include "icache_defs.svh"

module icache_ctrl
    import icache_pkg::*, mem_bus_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    input  logic        req_valid,
    input  fetch_addr_t req_addr,
    output logic        req_ready,
    output logic        resp_valid,
    output tag_t        req_tag,

    input  logic        hit,
    input  way_idx_t    hit_way,

    output lookup_t     lookup,
    output fill_t       fill,
    output way_mask_t   victim,

    output logic        ar_valid,
    input  logic        ar_ready,
    output fetch_addr_t ar_addr,

    input  logic        r_valid,
    input  r_beat_t     r_beat
);

    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_refill_addr,
        st_refill_data,
        st_replay
    } ctrl_state_t;

    ctrl_state_t             state;
    ctrl_state_t             state_next;
    fetch_addr_t             req_r;
    offset_t                 beat_cnt;
    way_mask_t               victim_r;
    way_idx_t                victim_idx;
    logic                    req_fire;
    logic                    miss;
    logic [`ICACHE_SETS-1:0] plru_root;
    logic [`ICACHE_SETS-1:0] plru_p0;
    logic [`ICACHE_SETS-1:0] plru_p1;

    // a hitting lookup frees the slot for the next request
    assign req_ready  = (state == st_idle) || (state == st_lookup && hit);
    assign req_fire   = req_valid && req_ready;
    assign miss       = (state == st_lookup) && !hit;
    assign resp_valid = (state == st_lookup) && hit;
    assign req_tag    = req_r.tag;

    always_comb begin
        lookup.en = req_fire || (state == st_replay);
        if (state == st_replay) begin
            lookup.index  = req_r.index;
            lookup.offset = req_r.offset;
        end else begin
            lookup.index  = req_addr.index;
            lookup.offset = req_addr.offset;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                if (req_fire) begin
                    state_next = st_lookup;
                end
            end
            st_lookup: begin
                if (!hit) begin
                    state_next = st_refill_addr;
                end else if (!req_fire) begin
                    state_next = st_idle;
                end
            end
            st_refill_addr: begin
                if (ar_ready) begin
                    state_next = st_refill_data;
                end
            end
            st_refill_data: begin
                if (r_valid && r_beat.last) begin
                    state_next = st_replay;
                end
            end
            st_replay: begin
                state_next = st_lookup;
            end
            default: begin
                state_next = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= st_idle;
            beat_cnt <= '0;
            victim_r <= '0;
        end else begin
            state <= state_next;
            if (miss) begin
                victim_r <= way_mask_t'(1) << victim_idx;
            end
            if (state == st_refill_addr && ar_ready) begin
                beat_cnt <= '0;
            end else if (fill.valid) begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire) begin
            req_r <= req_addr;
        end
    end

    // tree plru where the root picks the pair and the pair bit picks the way
    assign victim_idx[1] = plru_root[req_r.index];
    assign victim_idx[0] = plru_root[req_r.index] ? plru_p1[req_r.index]
                                                  : plru_p0[req_r.index];

    always_ff @(posedge clk) begin
        if (rst) begin
            plru_root <= '0;
            plru_p0   <= '0;
            plru_p1   <= '0;
        end else if (resp_valid) begin
            // point away from the hit way
            plru_root[req_r.index] <= ~hit_way[1];
            if (hit_way[1]) begin
                plru_p1[req_r.index] <= ~hit_way[0];
            end else begin
                plru_p0[req_r.index] <= ~hit_way[0];
            end
        end
    end

    assign victim = victim_r;

    assign ar_valid = (state == st_refill_addr);
    assign ar_addr  = '{tag: req_r.tag, index: req_r.index, offset: '0, byte_sel: '0};

    assign fill = '{
        valid:  (state == st_refill_data) && r_valid,
        index:  req_r.index,
        offset: beat_cnt,
        tag:    req_r.tag,
        last:   r_beat.last,
        data:   r_beat.data
    };

endmodule

// ==== icache_hit_select.sv ====
`timescale 1ns/1ps
`include "icache_defs.svh"

module icache_hit_select
    import icache_pkg::*;
(
    input  way_out_t results [`ICACHE_WAYS],
    output logic     hit,
    output way_idx_t hit_way,
    output word_t    word
);

    always_comb begin
        hit = 1'b0;
        for (int i = 0; i < `ICACHE_WAYS; i++) begin
            hit = hit | results[i].hit;
        end
    end

    // at most one way hits, so the encoder needs no priority
    always_comb begin
        hit_way = '0;
        for (int i = 0; i < `ICACHE_WAYS; i++) begin
            if (results[i].hit) begin
                hit_way = way_idx_t'(i);
            end
        end
    end

    assign word = results[hit_way].word;

endmodule

// ==== icache_way.sv ====
`timescale 1ns/1ps
`include "icache_defs.svh"

module icache_way
    import icache_pkg::*;
(
    input  logic     clk,
    input  logic     rst,

    input  lookup_t  lookup,
    input  tag_t     cmp_tag,

    input  fill_t    fill,
    input  logic     fill_sel,

    output way_out_t result
);

    tag_t                    tag_mem  [`ICACHE_SETS];
    word_t                   data_mem [`ICACHE_SETS * `ICACHE_LINE_WORDS];
    logic [`ICACHE_SETS-1:0] valid_bits;

    logic                    rd_valid;
    tag_t                    rd_tag;
    word_t                   rd_data;
    logic                    wr_en;

    assign wr_en = fill.valid && fill_sel;

    // tag and valid are committed with the last beat only
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_bits <= '0;
        end else if (wr_en && fill.last) begin
            valid_bits[fill.index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            data_mem[{fill.index, fill.offset}] <= fill.data;
            if (fill.last) begin
                tag_mem[fill.index] <= fill.tag;
            end
        end
    end

    // synchronous read
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_valid <= 1'b0;
        end else if (lookup.en) begin
            rd_valid <= valid_bits[lookup.index];
        end
    end

    always_ff @(posedge clk) begin
        if (lookup.en) begin
            rd_tag  <= tag_mem[lookup.index];
            rd_data <= data_mem[{lookup.index, lookup.offset}];
        end
    end

    assign result.hit  = rd_valid && (rd_tag == cmp_tag);
    assign result.word = rd_data;

endmodule

// ==== mem_bus_pkg.sv ====
`include "icache_defs.svh"

package mem_bus_pkg;

    // read data beat without a ready
    typedef struct packed {
        logic [`ICACHE_WORD_W-1:0] data;
        logic                      last;
    } r_beat_t;

endpackage

// ==== icache_pkg.sv ====
`include "icache_defs.svh"

package icache_pkg;

    localparam int unsigned INDEX_W   = $clog2(`ICACHE_SETS);
    localparam int unsigned OFFSET_W  = $clog2(`ICACHE_LINE_WORDS);
    localparam int unsigned BYTE_W    = $clog2(`ICACHE_WORD_W / 8);
    localparam int unsigned TAG_W     = `ICACHE_ADDR_W - INDEX_W - OFFSET_W - BYTE_W;
    localparam int unsigned WAY_IDX_W = $clog2(`ICACHE_WAYS);

    typedef logic [`ICACHE_WORD_W-1:0] word_t;
    typedef logic [TAG_W-1:0]          tag_t;
    typedef logic [INDEX_W-1:0]        index_t;
    typedef logic [OFFSET_W-1:0]       offset_t;
    typedef logic [WAY_IDX_W-1:0]      way_idx_t;
    typedef logic [`ICACHE_WAYS-1:0]   way_mask_t;

    typedef struct packed {
        tag_t              tag;
        index_t            index;
        offset_t           offset;
        logic [BYTE_W-1:0] byte_sel;
    } fetch_addr_t;

    // read request to all ways
    typedef struct packed {
        logic    en;
        index_t  index;
        offset_t offset;
    } lookup_t;

    // one refill beat
    typedef struct packed {
        logic    valid;
        index_t  index;
        offset_t offset;
        tag_t    tag;
        logic    last;
        word_t   data;
    } fill_t;

    typedef struct packed {
        logic  hit;
        word_t word;
    } way_out_t;

endpackage

// ==== icache_defs.svh ====
`ifndef ICACHE_DEFS_SVH
`define ICACHE_DEFS_SVH

// cache geometry
`define ICACHE_WAYS        4
`define ICACHE_SETS        128
`define ICACHE_LINE_WORDS  8

// bus widths
`define ICACHE_ADDR_W      32
`define ICACHE_WORD_W      32

`endif
